//--- bench/tcu_fedp_assertions.sv
// Output checks for the fused dot-product unit.
// Bound into every tcu_fedp instance, watches the top-level ports only.

`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_fedp_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 enable,
    input logic                 out_valid,
    input logic [`TCU_XLEN-1:0] d_val
);

    // Synchronous reset empties the pipe
    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // A stall freezes the result register
    stall_holds_output: assert property (@(posedge clk) disable iff (reset)
        !enable |=> $stable(d_val) && $stable(out_valid))
        else $error("d_val or out_valid changed while enable was low");

    valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(out_valid))
        else $error("out_valid is unknown");

endmodule

bind tcu_fedp tcu_fedp_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .out_valid (out_valid),
    .d_val     (d_val)
);

//--- bench/tcu_fedp_tb.sv
// Testbench for the fused dot-product unit.
// Drives directed and random fp16/bf16 operations, with gaps and stalls,
// and checks every result in order against an integer model of the rule.

`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_fedp_tb;
    import tcu_pkg::*;

    localparam int CLK_PERIOD = 100;
    // Enabled edges from issue to result
    localparam int LAT_CYCLES = 4;
    localparam int RAND_OPS   = 150;
    localparam int STALL_OPS  = 150;
    localparam int MAX_STALL  = 3;
    // Directed ops, every random slot, worst-case stalls and six drains
    localparam int WATCHDOG_CYCLES = 20 + RAND_OPS + STALL_OPS * (1 + MAX_STALL)
                                     + 6 * (4 * LAT_CYCLES + 2) + 20;

    logic                             clk;
    logic                             reset;
    logic                             enable;
    logic                             in_valid;
    logic [2:0]                       fmt_s;
    logic [`TCU_N-1:0][`TCU_XLEN-1:0] a_row;
    logic [`TCU_N-1:0][`TCU_XLEN-1:0] b_col;
    logic [`TCU_XLEN-1:0]             c_val;
    logic [`TCU_XLEN-1:0]             d_val;
    logic                             out_valid;

    logic [31:0] exp_q[$];
    logic [31:0] rng_state = 32'h299a_feb0;
    logic [31:0] expd;
    logic        en_edge;
    int          errors;
    int          results;
    int          issued;
    int          err_base;
    int          stall_len;

    tcu_fedp dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Expected fp32 word with terms held as integer magnitudes scaled by 2^(e-150)
    function automatic logic [31:0] ref_dot(input logic [2:0] fmt,
            input logic [`TCU_N-1:0][31:0] a, input logic [`TCU_N-1:0][31:0] b,
            input logic [31:0] c);
        logic [15:0] ha;
        logic [15:0] hb;
        int          e[TERMS];
        longint      m[TERMS];
        bit          neg[TERMS];
        int          ea;
        int          eb;
        int          max_e;
        int          p;
        longint      sum;
        longint      mag;
        longint      keep;
        longint      rem;
        bit          bf;
        bf = (fmt == 3'd1);
        for (int k = 0; k < TERMS - 1; k++) begin
            ha = a[k / 2][16 * (k % 2) +: 16];
            hb = b[k / 2][16 * (k % 2) +: 16];
            ea = bf ? int'(ha[14:7]) : int'(ha[14:10]);
            eb = bf ? int'(hb[14:7]) : int'(hb[14:10]);
            if (bf) begin
                m[k] = longint'(int'({1'b1, ha[6:0]}) * int'({1'b1, hb[6:0]})) << 8;
            end else begin
                m[k] = longint'(int'({1'b1, ha[9:0]}) * int'({1'b1, hb[9:0]})) << 2;
            end
            e[k] = bf ? ea + eb - 126 : ea + eb + 98;
            if (ea == 0 || eb == 0) m[k] = 0;
            neg[k] = ha[15] ^ hb[15];
        end
        e[TERMS-1]   = int'(c[30:23]);
        m[TERMS-1]   = (c[30:23] == 8'd0) ? 64'd0 : longint'({1'b1, c[22:0]});
        neg[TERMS-1] = c[31];
        // Dead terms have no magnitude and stay out of the maximum
        max_e = 0;
        for (int k = 0; k < TERMS; k++) begin
            if (m[k] != 0 && e[k] > max_e) max_e = e[k];
        end
        sum = 0;
        for (int k = 0; k < TERMS; k++) begin
            mag = (m[k] == 0) ? 64'd0 : m[k] >> (max_e - e[k]);
            sum = neg[k] ? sum - mag : sum + mag;
        end
        if (sum == 0) return 32'h0;
        mag = (sum < 0) ? -sum : sum;
        p = 0;
        for (int k = 0; k < 40; k++) begin
            if (mag[k]) p = k;
        end
        keep = (p > 23) ? mag >> (p - 23) : mag << (23 - p);
        if (p > 23) begin
            // Remainder doubled so the halfway point is one whole unit
            rem = (mag - (keep << (p - 23))) << 1;
            if (rem > (64'd1 << (p - 23)) || (rem == (64'd1 << (p - 23)) && keep[0])) begin
                keep++;
            end
        end
        if (keep[24]) begin
            keep = keep >> 1;
            p++;
        end
        return {sum < 0, 8'(max_e + p - 23), keep[22:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic issue_op(input logic v, input logic [2:0] fmt,
            input logic [`TCU_N-1:0][31:0] a, input logic [`TCU_N-1:0][31:0] b,
            input logic [31:0] c);
        @(posedge clk);
        #5;
        enable   = 1'b1;
        in_valid = v;
        fmt_s    = fmt;
        a_row    = a;
        b_col    = b;
        c_val    = c;
        if (v) begin
            exp_q.push_back(ref_dot(fmt, a, b, c));
            issued++;
        end
    endtask

    // Frozen cycle with junk on the inputs that must not be captured
    task automatic stall_cycle();
        @(posedge clk);
        #5;
        enable   = 1'b0;
        in_valid = 1'b1;
        c_val    = next_rand();
    endtask

    function automatic logic [15:0] rand_half(input bit bf);
        logic [31:0] r;
        logic [7:0]  e;
        r = next_rand();
        e = bf ? 8'(112 + r[15:8] % 32) : 8'(5 + r[15:8] % 20);
        if (r[2:0] == 3'd0) e = 8'd0;
        return bf ? {r[31], e, r[22:16]} : {r[31], e[4:0], r[25:16]};
    endfunction

    task automatic rand_op(input bit gaps);
        logic [`TCU_N-1:0][31:0] a;
        logic [`TCU_N-1:0][31:0] b;
        logic [31:0]             r;
        logic [31:0]             c;
        logic [2:0]              fmt;
        r = next_rand();
        // Unused format codes ride along as fp16
        fmt = r[0] ? 3'd1 : ((r[3:1] == 3'd0) ? 3'd5 : 3'd0);
        for (int k = 0; k < `TCU_N; k++) begin
            a[k] = {rand_half(fmt == 3'd1), rand_half(fmt == 3'd1)};
            b[k] = {rand_half(fmt == 3'd1), rand_half(fmt == 3'd1)};
        end
        c = next_rand();
        c = (r[11:8] == 4'd0) ? 32'h0 : {r[31], 8'(100 + r[23:16] % 56), c[22:0]};
        issue_op(!gaps || r[6:4] != 3'd0, fmt, a, b, c);
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 4 * LAT_CYCLES) begin
            issue_op(1'b0, 3'd0, '0, '0, 32'h0);
            waited++;
        end
        repeat (2) issue_op(1'b0, 3'd0, '0, '0, 32'h0);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d results never came out", name, exp_q.size());
            exp_q.delete();
        end
        $display("[TEST] %-20s %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    // A new result shows after each enabled edge and is sampled mid-cycle
    initial begin
        forever begin
            @(posedge clk);
            en_edge = enable;
            @(negedge clk);
            if (!reset && en_edge && out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Result appeared on d_val with no operation outstanding");
                end else begin
                    expd = exp_q.pop_front();
                    check_value("d_val", expd, d_val);
                    results++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        enable   = 1'b0;
        in_valid = 1'b0;
        fmt_s    = 3'd0;
        a_row    = '0;
        b_col    = '0;
        c_val    = '0;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;

        repeat (3) begin
            issue_op(1'b0, 3'd0, '0, '0, 32'h0);
            check_value("out_valid", 32'd0, 32'(out_valid));
        end
        check_value("ref_dot", 32'h4100_0000,
                    ref_dot(3'd0, 64'h3c00_3c00_3c00_3c00, 64'h4000_4000_4000_4000, 32'h0));
        issue_op(1'b1, 3'd0, 64'h3c00_3c00_3c00_3c00, 64'h4000_4000_4000_4000, 32'h0);
        for (int cyc = 1; cyc <= LAT_CYCLES; cyc++) begin
            issue_op(1'b0, 3'd0, '0, '0, 32'h0);
            check_value("out_valid", 32'(cyc == LAT_CYCLES), 32'(out_valid));
        end
        finish_test("reset_latency");

        issue_op(1'b1, 3'd0, 64'h3c00_bc00_4000_3800, 64'h4200_4200_c200_3c00, 32'h0);
        issue_op(1'b1, 3'd0, 64'h3c00_3c00_3c00_3c00, 64'h4500_b800_3555_4000, 32'h4120_0000);
        issue_op(1'b1, 3'd0, 64'h0000_0001_3c00_8000, 64'h4000_4000_4000_4000, 32'hc0a0_0000);
        issue_op(1'b1, 3'd0, 64'h7bff_0400_57ff_3c01, 64'h7bff_0400_2001_bfff, 32'h3f80_0000);
        finish_test("fp16_directed");

        issue_op(1'b1, 3'd1, 64'h3f80_bfc0_4000_3f00, 64'h4000_4000_3f80_c040, 32'h0);
        issue_op(1'b1, 3'd1, 64'h4b00_3400_4b12_0000, 64'h4b00_3400_cb12_3f80, 32'h4f00_0000);
        issue_op(1'b1, 3'd1, 64'h0040_3f80_8000_42c8, 64'h3f80_0012_3f80_c2c8, 32'h3f80_0000);
        finish_test("bf16_directed");

        // Exact cancellation, both halfway cases, partial and total alignment loss
        check_value("ref_dot", 32'h40a0_0000,
            ref_dot(3'd0, 64'h3c00_0000_0000_0000, 64'h3c00_0000_0000_0000, 32'h407f_ffff));
        // Dropped bits leave an exact tie that rounds down to even
        check_value("ref_dot", 32'h4b80_0000,
            ref_dot(3'd0, 64'h3c01_0000_0000_0000, 64'h4000_0000_0000_0000, 32'h4b7f_ffff));
        issue_op(1'b1, 3'd0, 64'h3c00_3c00_3c00_3c00, 64'h3c00_bc00_4000_c000, 32'h0);
        issue_op(1'b1, 3'd0, 64'h3c00_0000_0000_0000, 64'hbc00_0000_0000_0000, 32'h3f80_0000);
        issue_op(1'b1, 3'd0, 64'h3c00_0000_0000_0000, 64'h3c00_0000_0000_0000, 32'h407f_ffff);
        issue_op(1'b1, 3'd0, 64'h3c00_0000_0000_0000, 64'h3c00_0000_0000_0000, 32'h407f_fffd);
        issue_op(1'b1, 3'd0, 64'h3c01_0000_0000_0000, 64'h4000_0000_0000_0000, 32'h4b7f_ffff);
        issue_op(1'b1, 3'd0, 64'h3c00_3c00_0000_0000, 64'h3c00_3c00_0000_0000, 32'h4e80_0000);
        finish_test("cancel_round_align");

        repeat (RAND_OPS) rand_op(1'b1);
        finish_test("random_stream");

        repeat (STALL_OPS) begin
            stall_len = int'(next_rand() % (MAX_STALL + 1));
            repeat (stall_len) stall_cycle();
            rand_op(1'b1);
        end
        finish_test("stall_stream");

        if (results != issued) begin
            errors++;
            $display("Issued %0d operations but checked %0d results", issued, results);
        end
        $display("Totals: %0d issued, %0d checked, %0d errors", issued, results, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the dot-product testbench with Verilator, run it and grade the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tcu_fedp.f \
    --top-module tcu_fedp_tb -o sim_tcu_fedp || { echo "Build failed"; exit 1; }
output=$(./obj_dir/sim_tcu_fedp)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Simulation passed" && exit 0 || exit 1

//--- tcu_fedp.f
+incdir+verilog
verilog/tcu_pkg.sv
verilog/tcu_acc_if.sv
verilog/tcu_pipe_reg.sv
verilog/tcu_fedp_decode.sv
verilog/tcu_fedp_execute.sv
verilog/tcu_fedp_result.sv
verilog/tcu_fedp.sv
bench/tcu_fedp_assertions.sv
bench/tcu_fedp_tb.sv

//--- verilog/tcu_acc_if.sv
// Link between the execute and result stages of the dot-product unit.
// Carries the sign-magnitude sum, the shared exponent and the valid bit.
// Execute drives it through src, result reads it through dst.

`timescale 1ns/1ps

interface tcu_acc_if;
    import tcu_pkg::*;

    logic             sign;
    logic [7:0]       max_exp;
    logic [ACC_W-1:0] sig;
    logic             valid;

    modport src (
        output sign, max_exp, sig, valid
    );

    modport dst (
        input sign, max_exp, sig, valid
    );

endinterface

//--- verilog/tcu_cfg.svh
// Build-time sizing for the tensor-core dot-product lane.
// Include this header in any file that sizes ports from the word count or width.
// Change TCU_N to widen the dot product; the word width stays at 32.

`ifndef TCU_CFG_SVH
`define TCU_CFG_SVH

// Number of 32-bit words in one row of A and one column of B
`define TCU_N 2

// Word width, each word packs two 16-bit elements
`define TCU_XLEN 32

`endif

//--- verilog/tcu_fedp.sv
// Fused dot-product unit for one tensor-core lane.
// Computes sum(a[i] * b[i]) + c over 2*TCU_N fp16 or bf16 element pairs
// and returns an fp32 result four enabled cycles later.
// Dropping enable freezes every stage, in_valid tags real operations.

`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_fedp (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic                             in_valid,
    input  logic [2:0]                       fmt_s,
    input  logic [`TCU_N-1:0][`TCU_XLEN-1:0] a_row,
    input  logic [`TCU_N-1:0][`TCU_XLEN-1:0] b_col,
    input  logic [`TCU_XLEN-1:0]             c_val,
    output logic [`TCU_XLEN-1:0]             d_val,
    output logic                             out_valid
);
    import tcu_pkg::*;

    // Decode to execute
    logic [7:0]                  dec_max_exp;
    logic [TERMS-1:0][SIG_W-1:0] dec_sigs;
    logic                        dec_valid;

    tcu_acc_if acc_link ();

    tcu_fedp_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .in_valid (in_valid),
        .fmt_s    (fmt_e'(fmt_s)),
        .a_row    (a_row),
        .b_col    (b_col),
        .c_val    (c_val),
        .max_exp  (dec_max_exp),
        .sigs     (dec_sigs),
        .valid    (dec_valid)
    );

    tcu_fedp_execute u_execute (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .max_exp (dec_max_exp),
        .sigs    (dec_sigs),
        .valid   (dec_valid),
        .acc     (acc_link.src)
    );

    tcu_fedp_result u_result (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .acc       (acc_link.dst),
        .d_val     (d_val),
        .out_valid (out_valid)
    );

endmodule

//--- verilog/tcu_fedp_decode.sv
// Decode stage of the dot-product unit.
// Unpacks fp16 or bf16 elements, forms every product as a 24-bit magnitude
// with an fp32-style exponent, decodes the fp32 accumulator, then aligns
// all terms to the largest exponent as signed values. Two register stages.

`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_fedp_decode (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          enable,
    input  logic                                          in_valid,
    input  tcu_pkg::fmt_e                                 fmt_s,
    input  logic [`TCU_N-1:0][`TCU_XLEN-1:0]              a_row,
    input  logic [`TCU_N-1:0][`TCU_XLEN-1:0]              b_col,
    input  logic [`TCU_XLEN-1:0]                          c_val,
    output logic [7:0]                                    max_exp,
    output logic [tcu_pkg::TERMS-1:0][tcu_pkg::SIG_W-1:0] sigs,
    output logic                                          valid
);
    import tcu_pkg::*;

    localparam int NPROD = 2 * `TCU_N;

    half_u [NPROD-1:0]             a_el;
    half_u [NPROD-1:0]             b_el;
    logic  [TERMS-1:0]             t_live;
    logic  [TERMS-1:0]             t_sign;
    logic  [TERMS-1:0][7:0]        t_exp;
    logic  [TERMS-1:0][23:0]       t_mag;
    logic  [TERMS-1:0][23:0]       sh_mag;
    logic  [TERMS-1:0][SIG_W-1:0]  aln;
    logic  [7:0]                   raw_max;

    // One product, value mag * 2^(exp - 150)
    function automatic void mul_term(
        input  half_u       a,
        input  half_u       b,
        input  logic        bf,
        output logic        live,
        output logic        sign,
        output logic [7:0]  exp,
        output logic [23:0] mag
    );
        logic [9:0]  ea;
        logic [9:0]  eb;
        logic [15:0] p_bf;
        logic [21:0] p_hp;
        ea   = bf ? 10'(a.bf16.exp) : 10'(a.fp16.exp);
        eb   = bf ? 10'(b.bf16.exp) : 10'(b.fp16.exp);
        p_bf = {1'b1, a.bf16.man} * {1'b1, b.bf16.man};
        p_hp = {1'b1, a.fp16.man} * {1'b1, b.fp16.man};
        // Zero and subnormal elements kill the product
        live = (ea != 10'd0) && (eb != 10'd0);
        // Sign sits in bit 15 under both views
        sign = a.fp16.sign ^ b.fp16.sign;
        if (bf) begin
            exp = 8'(ea + eb - 10'd126);
            mag = {p_bf, 8'd0};
        end else begin
            exp = 8'(ea + eb + 10'd98);
            mag = {p_hp, 2'd0};
        end
    endfunction

    // Low half of each word is the even element
    for (genvar i = 0; i < `TCU_N; i++) begin : g_unpack
        assign a_el[2*i]   = a_row[i][15:0];
        assign a_el[2*i+1] = a_row[i][31:16];
        assign b_el[2*i]   = b_col[i][15:0];
        assign b_el[2*i+1] = b_col[i][31:16];
    end

    always_comb begin
        for (int i = 0; i < NPROD; i++) begin
            mul_term(a_el[i], b_el[i], fmt_s == FMT_BF16,
                     t_live[i], t_sign[i], t_exp[i], t_mag[i]);
        end
        // Accumulator is already fp32, last term slot
        t_live[TERMS-1] = c_val[30:23] != 8'd0;
        t_sign[TERMS-1] = c_val[31];
        t_exp[TERMS-1]  = c_val[30:23];
        t_mag[TERMS-1]  = {1'b1, c_val[22:0]};

        raw_max = 8'd0;
        for (int i = 0; i < TERMS; i++) begin
            if (t_live[i] && (t_exp[i] > raw_max)) begin
                raw_max = t_exp[i];
            end
        end
    end

    // Align to the largest exponent, shifted-out bits are lost
    always_comb begin
        for (int i = 0; i < TERMS; i++) begin
            sh_mag[i] = t_live[i] ? (t_mag[i] >> (raw_max - t_exp[i])) : 24'd0;
            aln[i]    = t_sign[i] ? -SIG_W'(sh_mag[i]) : SIG_W'(sh_mag[i]);
        end
    end

    tcu_pipe_reg #(
        .DATAW (1 + 8 + TERMS * SIG_W),
        .DEPTH (DEC_DEPTH)
    ) pipe_dec (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  ({in_valid, raw_max, aln}),
        .data_out ({valid, max_exp, sigs})
    );

endmodule

//--- verilog/tcu_fedp_execute.sv
// Execute stage of the dot-product unit.
// Compresses the aligned signed terms with 3:2 carry-save adders, resolves
// the pair with one adder and turns the total into sign and magnitude.
// One register stage, driven onto the execute-to-result link.

`timescale 1ns/1ps

module tcu_fedp_execute (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          enable,
    input  logic [7:0]                                    max_exp,
    input  logic [tcu_pkg::TERMS-1:0][tcu_pkg::SIG_W-1:0] sigs,
    input  logic                                          valid,
    tcu_acc_if.src                                        acc
);
    import tcu_pkg::*;

    logic [ACC_W-1:0]       cs_sum;
    logic [ACC_W-1:0]       cs_car;
    logic [ACC_W-1:0]       addend;
    logic [ACC_W-1:0]       nxt_sum;
    logic [ACC_W-1:0]       nxt_car;
    logic [ACC_W-1:0]       total;
    logic                   acc_sign;
    logic [ACC_W-1:0]       acc_mag;
    logic [ACC_W+9:0]       acc_q;

    function automatic logic [ACC_W-1:0] sext(input logic [SIG_W-1:0] v);
        return {{(ACC_W - SIG_W){v[SIG_W-1]}}, v};
    endfunction

    // Carry-save compression, one 3:2 row per extra term
    always_comb begin
        cs_sum = sext(sigs[0]);
        cs_car = sext(sigs[1]);
        for (int i = 2; i < TERMS; i++) begin
            addend  = sext(sigs[i]);
            nxt_sum = cs_sum ^ cs_car ^ addend;
            nxt_car = ((cs_sum & cs_car) | (cs_sum & addend) | (cs_car & addend)) << 1;
            cs_sum  = nxt_sum;
            cs_car  = nxt_car;
        end
    end

    assign total    = cs_sum + cs_car;
    assign acc_sign = total[ACC_W-1];
    assign acc_mag  = acc_sign ? -total : total;

    tcu_pipe_reg #(
        .DATAW (ACC_W + 10),
        .DEPTH (EXE_DEPTH)
    ) pipe_exe (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  ({valid, acc_sign, max_exp, acc_mag}),
        .data_out (acc_q)
    );

    assign {acc.valid, acc.sign, acc.max_exp, acc.sig} = acc_q;

endmodule

//--- verilog/tcu_fedp_result.sv
// Result stage of the dot-product unit.
// Normalizes the sign-magnitude sum to 1.23 form, rounds to nearest even
// and packs an fp32 word. A zero sum always yields +0.
// One register stage feeding d_val and out_valid.

`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_fedp_result (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    tcu_acc_if.dst               acc,
    output logic [`TCU_XLEN-1:0] d_val,
    output logic                 out_valid
);
    import tcu_pkg::*;

    localparam int                LEAD_W  = $clog2(ACC_W);
    localparam logic [LEAD_W-1:0] TOP_BIT = LEAD_W'(ACC_W - 1);

    logic [LEAD_W-1:0]    lead;
    logic [ACC_W-1:0]     norm;
    logic                 lsb;
    logic                 guard;
    logic                 sticky;
    logic                 round_up;
    logic [24:0]          mant_rnd;
    logic [22:0]          frac;
    logic [9:0]           exp_adj;
    logic [`TCU_XLEN-1:0] fp32_res;

    // Highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < ACC_W; i++) begin
            if (acc.sig[i]) begin
                lead = LEAD_W'(i);
            end
        end
    end

    // Leading one moved to the top bit
    assign norm = acc.sig << (TOP_BIT - lead);

    // Bits under the 24-bit significand decide the rounding
    assign lsb      = norm[ACC_W-24];
    assign guard    = norm[ACC_W-25];
    assign sticky   = |norm[ACC_W-26:0];
    assign round_up = guard & (sticky | lsb);

    assign mant_rnd = {1'b0, norm[ACC_W-1 -: 24]} + 25'(round_up);

    // Round carry leaves 1.000..., so the fraction is taken one bit higher
    assign frac    = mant_rnd[24] ? mant_rnd[23:1] : mant_rnd[22:0];
    assign exp_adj = 10'(acc.max_exp) + 10'(lead) + 10'(mant_rnd[24]) - 10'd23;

    assign fp32_res = (acc.sig == '0) ? '0 : {acc.sign, exp_adj[7:0], frac};

    tcu_pipe_reg #(
        .DATAW (1 + `TCU_XLEN),
        .DEPTH (RES_DEPTH)
    ) pipe_res (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  ({acc.valid, fp32_res}),
        .data_out ({out_valid, d_val})
    );

endmodule

//--- verilog/tcu_pipe_reg.sv
// Chain of DEPTH registers that move together while enable is high.
// Every stage of the dot-product unit registers its outputs through this.
// Synchronous reset clears the whole chain.

`timescale 1ns/1ps

module tcu_pipe_reg #(
    parameter int DATAW = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out
);

    logic [DEPTH-1:0][DATAW-1:0] stages;

    always_ff @(posedge clk) begin
        if (reset) begin
            stages <= '0;
        end else if (enable) begin
            stages[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Oldest entry leaves the chain
    assign data_out = stages[DEPTH-1];

endmodule

//--- verilog/tcu_pkg.sv
// Shared types and derived sizes for the fused dot-product unit.
// Modules import this package inside their bodies and use scoped
// names in their port lists.

`include "tcu_cfg.svh"

package tcu_pkg;

    // Source element format, unused codes fall back to fp16
    typedef enum logic [2:0] {
        FMT_FP16 = 3'd0,
        FMT_BF16 = 3'd1
    } fmt_e;

    // One 16-bit element seen either as fp16 or as bf16
    typedef union packed {
        struct packed {
            logic       sign;
            logic [4:0] exp;
            logic [9:0] man;
        } fp16;
        struct packed {
            logic       sign;
            logic [7:0] exp;
            logic [6:0] man;
        } bf16;
    } half_u;

    // All element products plus the accumulator
    localparam int TERMS = 2 * `TCU_N + 1;

    // Signed width of one aligned term, 24-bit magnitude plus sign
    localparam int SIG_W = 25;

    // Reduced sum needs growth bits for the term count
    localparam int ACC_W = SIG_W + $clog2(TERMS);

    // Pipeline depth per stage and end to end
    localparam int DEC_DEPTH = 2;
    localparam int EXE_DEPTH = 1;
    localparam int RES_DEPTH = 1;
    localparam int LATENCY   = DEC_DEPTH + EXE_DEPTH + RES_DEPTH;

endpackage
